//--- logic/fxp_pkg.sv
package fxp_pkg;

    // word width and default binary point
    localparam int word_bits = 16;
    localparam int frac_bits_default = 10;

    // largest 15-bit magnitude
    localparam logic [14:0] mag_max = 15'h7FFF;

    // sign-magnitude word, sign on top
    typedef struct packed {
        logic        sign;
        logic [14:0] mag;
    } fxp_t;

    // sign-magnitude to 32-bit two's complement, exact
    function automatic logic signed [31:0] to_acc(fxp_t v);
        logic signed [31:0] m;
        m = {17'd0, v.mag};
        return v.sign ? -m : m;
    endfunction

    // two's complement back to a word
    // magnitude saturates, zero keeps sign 0
    function automatic fxp_t from_acc(logic signed [31:0] s);
        logic [31:0] m;
        fxp_t        r;
        m = s[31] ? unsigned'(-s) : unsigned'(s);
        r.sign = s[31];
        r.mag = (m > 32'(mag_max)) ? mag_max : m[14:0];
        return r;
    endfunction

endpackage

//--- logic/net_pkg.sv
package net_pkg;

    // feature and score counts
    localparam int n_in = 10;
    localparam int n_out = 2;
    // words per activation bank, widest layer input
    localparam int buf_depth = 10;

    // rom layout, weights then bias per neuron
    localparam logic [6:0] base_hidden1 = 7'd0;
    localparam logic [6:0] base_latent = 7'd66;
    localparam logic [6:0] base_hidden2 = 7'd73;
    localparam logic [6:0] base_output = 7'd85;
    localparam int rom_words = 99;

    typedef enum logic [1:0] {
        layer_hidden1,
        layer_latent,
        layer_hidden2,
        layer_output
    } layer_e;

    typedef enum logic [1:0] {
        act_none,
        act_softplus,
        act_sigmoid
    } act_e;

    // shape of one dense layer
    typedef struct packed {
        logic [3:0] fan_in;
        logic [3:0] n_neurons;
        logic [6:0] rom_base;
        act_e       act;
        logic [2:0] spare;
    } layer_desc_t;

    function automatic layer_desc_t layer_table(layer_e layer);
        layer_desc_t d;
        d = '0;
        case (layer)
            layer_hidden1: d = '{4'd10, 4'd6, base_hidden1, act_softplus, 3'd0};
            layer_latent:  d = '{4'd6, 4'd1, base_latent, act_none, 3'd0};
            layer_hidden2: d = '{4'd1, 4'd6, base_hidden2, act_softplus, 3'd0};
            default:       d = '{4'd6, 4'd2, base_output, act_sigmoid, 3'd0};
        endcase
        return d;
    endfunction

endpackage

//--- logic/fxp_mac.sv
`timescale 1ns/1ns

module fxp_mac #(
    parameter int frac_bits = fxp_pkg::frac_bits_default
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          clear,
    input  logic          acc_en,
    input  logic          finish,
    input  fxp_pkg::fxp_t w,
    input  fxp_pkg::fxp_t a,
    output fxp_pkg::fxp_t result,
    output logic          result_valid
);

    logic [29:0]        prod_full;
    logic [29:0]        prod_mag;
    logic signed [31:0] prod_s;
    logic signed [31:0] acc;
    logic signed [31:0] acc_base;
    logic signed [31:0] sum_bias;

    // full 15x15 product, then drop the fraction bits
    assign prod_full = w.mag * a.mag;
    assign prod_mag = prod_full >> frac_bits;
    // product sign from both operands
    assign prod_s = (w.sign ^ a.sign) ? -$signed({2'b00, prod_mag})
                                      : $signed({2'b00, prod_mag});

    // first weight of a neuron starts from zero
    assign acc_base = clear ? 32'sd0 : acc;

    // bias sits on w during finish
    assign sum_bias = acc + fxp_pkg::to_acc(w);

    // accumulator, exact sum
    always_ff @(posedge clk) begin
        if (acc_en) begin
            acc <= acc_base + prod_s;
        end
    end

    // neuron value, saturated back to a word
    always_ff @(posedge clk) begin
        if (finish) begin
            result <= fxp_pkg::from_acc(sum_bias);
        end
    end

    // one pulse per finished neuron
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= finish;
        end
    end

endmodule

//--- logic/activation_unit.sv
`timescale 1ns/1ns

module activation_unit #(
    parameter int frac_bits = fxp_pkg::frac_bits_default
) (
    input  net_pkg::act_e kind,
    input  fxp_pkg::fxp_t d,
    output fxp_pkg::fxp_t q
);

    // breakpoints at 0.5, 1.0 and 2.0
    localparam logic signed [31:0] one_v = 32'sd1 <<< frac_bits;
    localparam logic signed [31:0] half_v = one_v >>> 1;
    localparam logic signed [31:0] two_v = one_v <<< 1;

    fxp_pkg::fxp_t      d_half;
    fxp_pkg::fxp_t      d_quarter;
    logic signed [31:0] x_v;
    logic signed [31:0] sp_sum;
    logic signed [31:0] sg_sum;

    assign x_v = fxp_pkg::to_acc(d);

    // scale by magnitude shift, sign kept
    assign d_half = '{sign: d.sign, mag: d.mag >> 1};
    assign d_quarter = '{sign: d.sign, mag: d.mag >> 2};

    // softplus middle segment x/2 + 1
    assign sp_sum = fxp_pkg::to_acc(d_half) + one_v;
    // sigmoid line x/4 + 0.5
    assign sg_sum = fxp_pkg::to_acc(d_quarter) + half_v;

    always_comb begin
        case (kind)
            net_pkg::act_softplus: begin
                if (x_v <= -two_v) begin
                    q = '0;
                end else if (x_v >= two_v) begin
                    q = d;
                end else begin
                    q = fxp_pkg::from_acc(sp_sum);
                end
            end
            net_pkg::act_sigmoid: begin
                // clamp into 0 .. 1.0
                if (sg_sum < 0) begin
                    q = '0;
                end else if (sg_sum > one_v) begin
                    q = fxp_pkg::from_acc(one_v);
                end else begin
                    q = fxp_pkg::from_acc(sg_sum);
                end
            end
            default: q = d;
        endcase
    end

endmodule

//--- logic/weight_rom.sv
`timescale 1ns/1ns

module weight_rom (
    input  logic          clk,
    input  logic [6:0]    addr,
    output fxp_pkg::fxp_t data
);

    // all layers back to back, weights then bias per neuron
    logic [fxp_pkg::word_bits-1:0] mem [net_pkg::rom_words];

    initial begin
        $readmemh("logic/weights.hex", mem);
    end

    // registered read, one cycle
    always_ff @(posedge clk) begin
        data <= mem[addr];
    end

endmodule

//--- logic/act_buffer.sv
`timescale 1ns/1ns

module act_buffer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                load,
    input  fxp_pkg::fxp_t [net_pkg::n_in-1:0]   x_in,
    input  logic                                rd_bank,
    input  logic [3:0]                          rd_idx,
    output fxp_pkg::fxp_t                       rd_data,
    input  logic                                wr_en,
    input  logic [3:0]                          wr_idx,
    input  fxp_pkg::fxp_t                       wr_data
);

    // two ping-pong banks
    fxp_pkg::fxp_t mem [2][net_pkg::buf_depth];

    always_ff @(posedge clk) begin
        if (load) begin
            // features always land in bank 0
            for (int i = 0; i < net_pkg::n_in; i++) begin
                mem[0][i] <= x_in[i];
            end
        end else if (wr_en) begin
            // layer output fills the bank not being read
            mem[!rd_bank][wr_idx] <= wr_data;
        end
    end

    // registered read, lines up with the rom
    // bias step reads past the end, give zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_idx < net_pkg::buf_depth) begin
            rd_data <= mem[rd_bank][rd_idx];
        end else begin
            rd_data <= '0;
        end
    end

endmodule

//--- logic/layer_sequencer.sv
`timescale 1ns/1ns

module layer_sequencer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    output logic [6:0]                          rom_addr,
    output logic                                rd_bank,
    output logic [3:0]                          rd_idx,
    output logic [3:0]                          wr_idx,
    output logic                                load,
    output logic                                clear,
    output logic                                acc_en,
    output logic                                finish,
    output net_pkg::act_e                       act_kind,
    input  logic                                result_valid,
    input  fxp_pkg::fxp_t                       act_q,
    output logic                                wr_en,
    output fxp_pkg::fxp_t [net_pkg::n_out-1:0]  y,
    output logic                                busy,
    output logic                                done
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } state_e;

    state_e                             state;
    net_pkg::layer_e                    layer;
    net_pkg::layer_e                    next_layer;
    net_pkg::layer_desc_t               desc;
    net_pkg::layer_desc_t               next_desc;
    logic [3:0]                         neuron;
    logic [3:0]                         in_idx;
    logic [3:0]                         wr_cnt;
    logic [6:0]                         rom_ptr;
    logic                               bias_step;
    logic                               last_neuron;
    logic                               last_result;
    logic                               final_result;
    fxp_pkg::fxp_t [net_pkg::n_out-1:0] y_stage;

    // shape of the current and the following layer
    assign desc = net_pkg::layer_table(layer);
    assign next_layer = net_pkg::layer_e'(layer + 2'd1);
    assign next_desc = net_pkg::layer_table(next_layer);

    // in_idx == fan_in means bias word on the rom
    assign bias_step = (in_idx == desc.fan_in);
    assign last_neuron = (neuron == desc.n_neurons - 4'd1);
    assign last_result = result_valid && (wr_cnt == desc.n_neurons - 4'd1);
    assign final_result = (state == st_drain) && last_result
                          && (layer == net_pkg::layer_output);

    assign load = start && (state == st_idle);
    assign rom_addr = rom_ptr;
    assign rd_idx = in_idx;
    assign wr_idx = wr_cnt;
    assign wr_en = result_valid && (state != st_idle);
    assign act_kind = desc.act;

    // mac strobes one cycle late, to match rom and buffer reads
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clear <= 1'b0;
            acc_en <= 1'b0;
            finish <= 1'b0;
        end else begin
            clear <= (state == st_run) && (in_idx == 4'd0);
            acc_en <= (state == st_run) && !bias_step;
            finish <= (state == st_run) && bias_step;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            layer <= net_pkg::layer_hidden1;
            neuron <= 4'd0;
            in_idx <= 4'd0;
            wr_cnt <= 4'd0;
            rom_ptr <= 7'd0;
            rd_bank <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            // one result per neuron, written in order
            if (wr_en) begin
                wr_cnt <= wr_cnt + 4'd1;
            end
            case (state)
                st_idle: begin
                    // features captured by load this cycle
                    if (start) begin
                        state <= st_run;
                        busy <= 1'b1;
                        layer <= net_pkg::layer_hidden1;
                        neuron <= 4'd0;
                        in_idx <= 4'd0;
                        wr_cnt <= 4'd0;
                        rom_ptr <= net_pkg::layer_table(net_pkg::layer_hidden1).rom_base;
                        rd_bank <= 1'b0;
                    end
                end
                st_run: begin
                    // one rom word per cycle
                    rom_ptr <= rom_ptr + 7'd1;
                    if (bias_step) begin
                        in_idx <= 4'd0;
                        if (last_neuron) begin
                            state <= st_drain;
                        end else begin
                            neuron <= neuron + 4'd1;
                        end
                    end else begin
                        in_idx <= in_idx + 4'd1;
                    end
                end
                st_drain: begin
                    // wait until the last neuron is written back
                    if (last_result) begin
                        wr_cnt <= 4'd0;
                        neuron <= 4'd0;
                        in_idx <= 4'd0;
                        if (layer == net_pkg::layer_output) begin
                            state <= st_idle;
                            busy <= 1'b0;
                            done <= 1'b1;
                        end else begin
                            // next layer reads what this one wrote
                            layer <= next_layer;
                            rom_ptr <= next_desc.rom_base;
                            rd_bank <= !rd_bank;
                            state <= st_run;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // scores gathered here, y only moves with done
    always_ff @(posedge clk) begin
        if (wr_en && (layer == net_pkg::layer_output) && (wr_cnt < net_pkg::n_out)) begin
            y_stage[wr_cnt] <= act_q;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            y <= '0;
        end else if (final_result) begin
            for (int i = 0; i < net_pkg::n_out; i++) begin
                y[i] <= (i == wr_cnt) ? act_q : y_stage[i];
            end
        end
    end

endmodule

//--- logic/arrhythmia_classifier.sv
`timescale 1ns/1ns

module arrhythmia_classifier #(
    parameter int frac_bits = fxp_pkg::frac_bits_default
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    input  fxp_pkg::fxp_t [net_pkg::n_in-1:0]   x,
    output fxp_pkg::fxp_t [net_pkg::n_out-1:0]  y,
    output logic                                busy,
    output logic                                done
);

    logic [6:0]    rom_addr;
    fxp_pkg::fxp_t rom_data;
    logic          rd_bank;
    logic [3:0]    rd_idx;
    logic [3:0]    wr_idx;
    fxp_pkg::fxp_t rd_data;
    logic          load;
    logic          clear;
    logic          acc_en;
    logic          finish;
    logic          wr_en;
    net_pkg::act_e act_kind;
    fxp_pkg::fxp_t mac_result;
    logic          mac_valid;
    fxp_pkg::fxp_t act_q;

    // walks layers, neurons and inputs
    layer_sequencer i_sequencer (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .rom_addr     (rom_addr),
        .rd_bank      (rd_bank),
        .rd_idx       (rd_idx),
        .wr_idx       (wr_idx),
        .load         (load),
        .clear        (clear),
        .acc_en       (acc_en),
        .finish       (finish),
        .act_kind     (act_kind),
        .result_valid (mac_valid),
        .act_q        (act_q),
        .wr_en        (wr_en),
        .y            (y),
        .busy         (busy),
        .done         (done)
    );

    weight_rom i_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    act_buffer i_buffer (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .x_in    (x),
        .rd_bank (rd_bank),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (act_q)
    );

    // single shared mac for every layer
    fxp_mac #(
        .frac_bits (frac_bits)
    ) i_mac (
        .clk          (clk),
        .reset        (reset),
        .clear        (clear),
        .acc_en       (acc_en),
        .finish       (finish),
        .w            (rom_data),
        .a            (rd_data),
        .result       (mac_result),
        .result_valid (mac_valid)
    );

    activation_unit #(
        .frac_bits (frac_bits)
    ) i_act (
        .kind (act_kind),
        .d    (mac_result),
        .q    (act_q)
    );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns = 10
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

//--- verif/arrhythmia_asserts.sv
`timescale 1ns/1ns

module arrhythmia_asserts (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic done
);

    // done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // engine is idle right after done
    idle_after_done: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
        else $error("busy was high in the cycle after done");

    // done only ends a run that was in progress
    done_needs_busy: assert property (@(posedge clk) disable iff (reset) done |-> $past(busy))
        else $error("done pulsed without busy in the cycle before");

endmodule

//--- verif/tb_arrhythmia.sv
`timescale 1ns/1ns

module tb_arrhythmia;

    localparam int frac_bits = fxp_pkg::frac_bits_default;
    localparam int one_word = 1 << frac_bits;
    // upper bound on cycles from start to done
    localparam int max_latency = 130;
    localparam int n_random = 200;
    localparam int n_sat = 20;
    // random, saturation, overlap, back to back and zero vectors
    localparam int n_vectors = n_random + n_sat + 7;
    localparam int watchdog_cycles = n_vectors * max_latency + 200;

    typedef fxp_pkg::fxp_t [net_pkg::n_in-1:0] feat_t;
    typedef fxp_pkg::fxp_t [net_pkg::n_out-1:0] score_t;

    logic   clk;
    logic   reset;
    logic   start;
    feat_t  x;
    score_t y;
    logic   busy;
    logic   done;
    int     error_count = 0;
    int     done_count = 0;

    // weight image for the model
    logic [15:0] rom_img [net_pkg::rom_words];

    tb_clock_gen #(
        .period_ns (10)
    ) i_clk (
        .clk (clk)
    );

    arrhythmia_classifier #(
        .frac_bits (frac_bits)
    ) i_dut (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .x     (x),
        .y     (y),
        .busy  (busy),
        .done  (done)
    );

    bind layer_sequencer arrhythmia_asserts i_asserts (
        .clk   (clk),
        .reset (reset),
        .busy  (busy),
        .done  (done)
    );

    // every done pulse, sampled mid-cycle
    always @(negedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    task automatic stop_on_error();
        error_count++;
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    // model arithmetic, sign-magnitude word to integer
    function automatic int word_value(logic [15:0] w);
        int m;
        m = w[14:0];
        return w[15] ? -m : m;
    endfunction

    // integer back to a word, magnitude saturated, zero positive
    function automatic logic [15:0] word_from(int v);
        int m;
        m = (v < 0) ? -v : v;
        if (m > 32767) begin
            m = 32767;
        end
        return {(v < 0), m[14:0]};
    endfunction

    // truncated product, sign from both operands
    function automatic int product_of(logic [15:0] w, logic [15:0] a);
        int wm;
        int am;
        int p;
        wm = w[14:0];
        am = a[14:0];
        p = (wm * am) >> frac_bits;
        return (w[15] ^ a[15]) ? -p : p;
    endfunction

    function automatic logic [15:0] activate(net_pkg::act_e kind, logic [15:0] d);
        int v;
        int part;
        v = word_value(d);
        case (kind)
            net_pkg::act_softplus: begin
                if (v <= -2 * one_word) begin
                    return 16'h0000;
                end
                if (v >= 2 * one_word) begin
                    return d;
                end
                // half of x plus 1.0
                part = d[14:0] >> 1;
                if (d[15]) begin
                    part = -part;
                end
                return word_from(part + one_word);
            end
            net_pkg::act_sigmoid: begin
                // quarter of x plus 0.5, clamped to 0 .. 1.0
                part = d[14:0] >> 2;
                if (d[15]) begin
                    part = -part;
                end
                part = part + one_word / 2;
                if (part < 0) begin
                    part = 0;
                end
                if (part > one_word) begin
                    part = one_word;
                end
                return word_from(part);
            end
            default: return d;
        endcase
    endfunction

    // whole network, layer after layer through the rom image
    function automatic score_t model_scores(feat_t f);
        logic [15:0]          cur [net_pkg::buf_depth];
        logic [15:0]          nxt [net_pkg::buf_depth];
        net_pkg::layer_desc_t desc;
        score_t               s;
        int                   addr;
        int                   acc;
        for (int i = 0; i < net_pkg::buf_depth; i++) begin
            cur[i] = (i < net_pkg::n_in) ? f[i] : 16'h0000;
            nxt[i] = 16'h0000;
        end
        for (int l = 0; l < 4; l++) begin
            desc = net_pkg::layer_table(net_pkg::layer_e'(l));
            addr = desc.rom_base;
            for (int n = 0; n < desc.n_neurons; n++) begin
                acc = 0;
                for (int i = 0; i < desc.fan_in; i++) begin
                    acc += product_of(rom_img[addr], cur[i]);
                    addr++;
                end
                // bias follows the weights
                acc += word_value(rom_img[addr]);
                addr++;
                nxt[n] = activate(desc.act, word_from(acc));
            end
            cur = nxt;
        end
        for (int o = 0; o < net_pkg::n_out; o++) begin
            s[o] = cur[o];
        end
        return s;
    endfunction

    function automatic feat_t random_vector(int max_mag);
        feat_t v;
        for (int i = 0; i < net_pkg::n_in; i++) begin
            v[i].sign = 1'($urandom_range(1));
            v[i].mag = 15'($urandom_range(max_mag));
        end
        return v;
    endfunction

    // full-scale magnitudes, random signs
    function automatic feat_t saturated_vector();
        feat_t v;
        for (int i = 0; i < net_pkg::n_in; i++) begin
            v[i].sign = 1'($urandom_range(1));
            v[i].mag = fxp_pkg::mag_max;
        end
        return v;
    endfunction

    // one-cycle start, driven just after the edge
    task automatic send_start(feat_t v);
        @(posedge clk);
        #1;
        x = v;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            cycles++;
            if (cycles > max_latency) begin
                $display("no done pulse within %0d cycles of start", max_latency);
                stop_on_error();
            end
            @(negedge clk);
        end
    endtask

    // called in the done cycle
    task automatic check_scores(feat_t v);
        score_t expected;
        expected = model_scores(v);
        assert (!busy) else begin
            $display("[ERROR] busy: expected 0, got %h", busy);
            stop_on_error();
        end
        for (int o = 0; o < net_pkg::n_out; o++) begin
            assert (y[o] == expected[o]) else begin
                $display("[ERROR] y[%0d]: expected %h, got %h", o, expected[o], y[o]);
                stop_on_error();
            end
            assert (y[o] != 16'h8000) else begin
                $display("[ERROR] y[%0d]: expected 0000, got negative zero %h", o, y[o]);
                stop_on_error();
            end
            // scores live in 0 .. 1.0
            assert (!y[o].sign && (y[o].mag <= one_word)) else begin
                $display("[ERROR] y[%0d]: expected 0000 to %h, got %h", o, one_word, y[o]);
                stop_on_error();
            end
        end
    endtask

    task automatic run_vector(feat_t v);
        send_start(v);
        wait_done();
        check_scores(v);
    endtask

    task automatic check_idle_after_reset();
        @(negedge clk);
        assert (!busy && !done && (y == '0)) else begin
            $display("[ERROR] busy/done/y: expected 0/0/00000000, got %h/%h/%h", busy, done, y);
            stop_on_error();
        end
        // nothing happens without start
        repeat (20) begin
            @(negedge clk);
            assert (!done) else begin
                $display("[ERROR] done: expected 0 before any start, got %h", done);
                stop_on_error();
            end
        end
    endtask

    // second start lands mid-run and must be dropped
    task automatic check_start_while_busy();
        feat_t va;
        feat_t vb;
        int    base;
        va = random_vector(4 * one_word);
        vb = random_vector(4 * one_word);
        send_start(va);
        // count settled, previous done long past
        base = done_count;
        repeat (5) @(posedge clk);
        send_start(vb);
        wait_done();
        check_scores(va);
        repeat (max_latency) @(negedge clk);
        assert (done_count == base + 1) else begin
            $display("[ERROR] done_count: expected %h, got %h", base + 1, done_count);
            stop_on_error();
        end
    endtask

    task automatic check_back_to_back();
        feat_t v1;
        feat_t v2;
        v1 = random_vector(4 * one_word);
        v2 = random_vector(4 * one_word);
        run_vector(v1);
        // start in the cycle after done
        send_start(v2);
        @(negedge clk);
        assert (busy) else begin
            $display("a start right after done was not accepted");
            stop_on_error();
        end
        wait_done();
        check_scores(v2);
    endtask

    task automatic check_zero_inputs();
        feat_t v;
        v = '0;
        run_vector(v);
        // negative zero everywhere
        for (int i = 0; i < net_pkg::n_in; i++) begin
            v[i] = 16'h8000;
        end
        run_vector(v);
        // mix of both zeros
        for (int i = 0; i < net_pkg::n_in; i++) begin
            v[i] = (i % 2 == 0) ? 16'h8000 : 16'h0000;
        end
        run_vector(v);
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        x = '0;
        void'($urandom(32'hebc1));
        $readmemh("logic/weights.hex", rom_img);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_idle_after_reset();
        for (int n = 0; n < n_random; n++) begin
            run_vector(random_vector(4 * one_word));
        end
        for (int n = 0; n < n_sat; n++) begin
            run_vector(saturated_vector());
        end
        check_start_while_busy();
        check_back_to_back();
        check_zero_inputs();
        if (error_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            stop_on_error();
        end
    end

    // hard limit on the whole run
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout, run did not finish within %0d cycles", watchdog_cycles);
        stop_on_error();
    end

endmodule

//--- logic/weights.hex
// one 16-bit sign-magnitude word per line, bit 15 sign, bits 14:0 magnitude, 1.0 = 0400
// layer by layer, neuron by neuron, fan-in weights then the bias
0180
8100
0240
80C0
0060
8200
0140
0090
8050
0120
0080
8140
0200
00A0
8180
0210
0070
80E0
8030
0160
8090
8100
0050
8060
0300
0110
8220
0190
0040
81A0
00D0
0030
0000
81C0
0130
8070
0250
00B0
8150
0280
0060
8120
01E0
0200
0090
0170
8190
8040
0120
02C0
8080
0150
0010
8230
8080
8020
80F0
0110
0170
8260
0040
01B0
8210
0240
00E0
0040
0300
8280
0200
8180
0340
8120
0100
0600
8100
8500
0080
0380
0000
8400
8200
0700
8300
0280
0180
0300
8200
0180
8280
0100
0220
8100
8240
0280
8100
0300
8180
0080
0140

//--- sim.f
logic/fxp_pkg.sv
logic/net_pkg.sv
logic/fxp_mac.sv
logic/activation_unit.sv
logic/weight_rom.sv
logic/act_buffer.sv
logic/layer_sequencer.sv
logic/arrhythmia_classifier.sv
verif/tb_clock_gen.sv
verif/arrhythmia_asserts.sv
verif/tb_arrhythmia.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_arrhythmia -f sim.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi
